/* include/lpif_settings.svh */
`ifndef LPIF_SETTINGS_SVH
`define LPIF_SETTINGS_SVH

// LPIF field widths
`define LPIF_DATA_W    512
`define LPIF_CRC_W     16
`define LPIF_STATE_W   4
`define LPIF_PROTID_W  2

// Packed flit and debug counters
`define LPIF_FLIT_W    537
`define LPIF_DBG_W     32

// One PHY channel word, four segments
`define PHY_W          320
`define PHY_SEG_W      80
// One marker at the top of each segment
`define MARKER_W       4

// Both strobe slots stay reserved in every mode
`define STB_POS_GEN2   1
`define STB_POS_GEN1   39

// Alignment delay counters
`define DELAY_W        16

// Channel width minus markers and strobe slots
`define PHY_PAYLOAD_W  314

`endif

/* project.f */
+incdir+include
rtl/lpif_pkg.sv
rtl/ll_auto_sync.sv
rtl/lpif_flit_pack.sv
rtl/lpif_phy_concat.sv
rtl/lpif_txrx_x8_q2_master_top.sv
sim/tb_lpif_txrx.sv

/* rtl/ll_auto_sync.sv */
`timescale 1ns/1ps
`include "lpif_settings.svh"

module ll_auto_sync
  import lpif_pkg::*;
(
  input  logic                 clk_wr,
  input  logic                 arst_n,
  // Raw link control levels
  input  logic                 tx_online,
  input  logic                 rx_online,
  // Phase lengths in clk_wr cycles
  input  logic [`DELAY_W-1:0]  delay_x_value,
  input  logic [`DELAY_W-1:0]  delay_y_value,
  input  logic [`DELAY_W-1:0]  delay_z_value,
  // User bits once the link is up
  input  logic [`MARKER_W-1:0] tx_mrk_userbit,
  input  logic                 tx_stb_userbit,
  // Delayed levels and generated bits
  output logic                 tx_online_delay,
  output logic                 rx_online_delay,
  output logic [`MARKER_W-1:0] tx_auto_mrk_userbit,
  output logic                 tx_auto_stb_userbit
);

  localparam logic [`DELAY_W-1:0] CNT_ONE = 1;

  sync_state_e         sync_state;
  sync_state_e         sync_state_nxt;
  logic [`DELAY_W-1:0] tx_cnt;
  logic [`DELAY_W-1:0] tx_cnt_nxt;
  logic [`DELAY_W-1:0] rx_cnt;
  logic                phase_done;

  ////////////////////////////////////////////////////////////
  // Transmit alignment FSM

  // Last cycle of the current training phase
  assign phase_done = (tx_cnt <= CNT_ONE);

  always_comb begin
    sync_state_nxt = sync_state;
    tx_cnt_nxt     = tx_cnt;
    if (!tx_online) begin
      // Offline drops straight back to idle
      sync_state_nxt = SYNC_IDLE;
      tx_cnt_nxt     = '0;
    end else begin
      case (sync_state)
        SYNC_IDLE: begin
          sync_state_nxt = SYNC_STROBE;
          tx_cnt_nxt     = delay_y_value;
        end
        SYNC_STROBE: begin
          if (phase_done) begin
            sync_state_nxt = SYNC_MARKER;
            tx_cnt_nxt     = delay_z_value;
          end else begin
            tx_cnt_nxt = tx_cnt - CNT_ONE;
          end
        end
        SYNC_MARKER: begin
          if (phase_done) begin
            sync_state_nxt = SYNC_ONLINE;
            tx_cnt_nxt     = '0;
          end else begin
            tx_cnt_nxt = tx_cnt - CNT_ONE;
          end
        end
        // Online holds until tx_online drops
        default: begin
          sync_state_nxt = SYNC_ONLINE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      sync_state <= SYNC_IDLE;
      tx_cnt     <= '0;
    end else begin
      sync_state <= sync_state_nxt;
      tx_cnt     <= tx_cnt_nxt;
    end
  end

  assign tx_online_delay = (sync_state == SYNC_ONLINE);

  // Generated strobe and markers
  // Markers persist at 1 through both training phases
  always_comb begin
    case (sync_state)
      SYNC_STROBE: begin
        tx_auto_stb_userbit = 1'b1;
        tx_auto_mrk_userbit = '1;
      end
      SYNC_MARKER: begin
        tx_auto_stb_userbit = tx_stb_userbit;
        tx_auto_mrk_userbit = '1;
      end
      SYNC_ONLINE: begin
        tx_auto_stb_userbit = tx_stb_userbit;
        tx_auto_mrk_userbit = tx_mrk_userbit;
      end
      default: begin
        tx_auto_stb_userbit = 1'b0;
        tx_auto_mrk_userbit = '0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Receive online delay

  // Word alignment time before the receive side opens
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_online) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (rx_cnt >= delay_x_value) begin
      rx_online_delay <= 1'b1;
    end else begin
      rx_cnt <= rx_cnt + CNT_ONE;
    end
  end

endmodule

/* rtl/lpif_flit_pack.sv */
`timescale 1ns/1ps
`include "lpif_settings.svh"

module lpif_flit_pack
  import lpif_pkg::*;
(
  input  logic                      clk_wr,
  input  logic                      arst_n,
  // Downstream fields
  input  logic [`LPIF_STATE_W-1:0]  dstrm_state,
  input  logic [`LPIF_PROTID_W-1:0] dstrm_protid,
  input  logic [`LPIF_DATA_W-1:0]   dstrm_data,
  input  logic                      dstrm_dvalid,
  input  logic [`LPIF_CRC_W-1:0]    dstrm_crc,
  input  logic                      dstrm_crc_valid,
  input  logic                      dstrm_valid,
  // Received flit from the PHY mapper
  input  logic [`LPIF_FLIT_W-1:0]   rx_upstream_data,
  // Transmit flit to the PHY mapper
  output logic [`LPIF_FLIT_W-1:0]   txfifo_downstream_data,
  // Upstream fields
  output lpif_state_e               ustrm_state,
  output logic [`LPIF_PROTID_W-1:0] ustrm_protid,
  output logic [`LPIF_DATA_W-1:0]   ustrm_data,
  output logic                      ustrm_dvalid,
  output logic [`LPIF_CRC_W-1:0]    ustrm_crc,
  output logic                      ustrm_crc_valid,
  output logic                      ustrm_valid,
  // Flit counters
  output logic [`LPIF_DBG_W-1:0]    tx_downstream_debug_status,
  output logic [`LPIF_DBG_W-1:0]    rx_upstream_debug_status
);

  localparam logic [`LPIF_DBG_W-1:0] DBG_ONE = 1;

  logic [`LPIF_STATE_W-1:0] ustrm_state_bits;
  logic [`LPIF_DBG_W-1:0]   tx_flit_cnt;
  logic [`LPIF_DBG_W-1:0]   rx_flit_cnt;

  ////////////////////////////////////////////////////////////
  // Flit layout

  // Valid in bit 0, state in the top four bits
  assign txfifo_downstream_data = {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                                   dstrm_crc, dstrm_crc_valid, dstrm_valid};

  // Same layout in reverse
  assign {ustrm_state_bits, ustrm_protid, ustrm_data, ustrm_dvalid,
          ustrm_crc, ustrm_crc_valid, ustrm_valid} = rx_upstream_data;

  assign ustrm_state = lpif_state_e'(ustrm_state_bits);

  ////////////////////////////////////////////////////////////
  // Debug flit counters

  // Wrap at 2^32
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_flit_cnt <= '0;
      rx_flit_cnt <= '0;
    end else begin
      if (dstrm_valid) begin
        tx_flit_cnt <= tx_flit_cnt + DBG_ONE;
      end
      if (ustrm_valid) begin
        rx_flit_cnt <= rx_flit_cnt + DBG_ONE;
      end
    end
  end

  assign tx_downstream_debug_status = tx_flit_cnt;
  assign rx_upstream_debug_status   = rx_flit_cnt;

endmodule

/* rtl/lpif_phy_concat.sv */
`timescale 1ns/1ps
`include "lpif_settings.svh"

module lpif_phy_concat (
  input  logic                    clk_wr,
  input  logic                    arst_n,
  // Flits to and from the packer
  input  logic [`LPIF_FLIT_W-1:0] tx_downstream_data,
  output logic [`LPIF_FLIT_W-1:0] rx_upstream_data,
  // PHY channel words
  output logic [`PHY_W-1:0]       tx_phy0,
  input  logic [`PHY_W-1:0]       rx_phy0,
  output logic [`PHY_W-1:0]       tx_phy1,
  input  logic [`PHY_W-1:0]       rx_phy1,
  // Strobe slot select
  input  logic                    m_gen2_mode,
  // Delayed online levels
  input  logic                    tx_online,
  input  logic                    rx_online,
  // Strobe and markers from the sequencer
  input  logic                    tx_stb_userbit,
  input  logic [`MARKER_W-1:0]    tx_mrk_userbit
);

  localparam int unsigned PAD_W = 2 * `PHY_PAYLOAD_W - `LPIF_FLIT_W;

  // Both channels' payload, channel 0 in the low half
  logic [2*`PHY_PAYLOAD_W-1:0] tx_payload;
  logic [2*`PHY_PAYLOAD_W-1:0] rx_payload;

  ////////////////////////////////////////////////////////////
  // Bit placement helpers

  // Strobe slots and segment tops
  function automatic logic is_ctrl_bit(input int unsigned pos);
    return (pos == `STB_POS_GEN2) || (pos == `STB_POS_GEN1) ||
           ((pos % `PHY_SEG_W) == (`PHY_SEG_W - 1));
  endfunction

  // Payload into free positions in ascending order
  function automatic logic [`PHY_W-1:0] spread_payload(
    input logic [`PHY_PAYLOAD_W-1:0] payload
  );
    logic [`PHY_W-1:0] word;
    int unsigned       k;
    word = '0;
    k    = 0;
    for (int unsigned i = 0; i < `PHY_W; i++) begin
      if (!is_ctrl_bit(i)) begin
        word[i] = payload[k];
        k++;
      end
    end
    return word;
  endfunction

  // Inverse of spread_payload
  function automatic logic [`PHY_PAYLOAD_W-1:0] gather_payload(
    input logic [`PHY_W-1:0] word
  );
    logic [`PHY_PAYLOAD_W-1:0] payload;
    int unsigned               k;
    payload = '0;
    k       = 0;
    for (int unsigned i = 0; i < `PHY_W; i++) begin
      if (!is_ctrl_bit(i)) begin
        payload[k] = word[i];
        k++;
      end
    end
    return payload;
  endfunction

  // Markers on segment tops, strobe in the mode's slot
  function automatic logic [`PHY_W-1:0] insert_ctrl(
    input logic [`PHY_W-1:0]    word,
    input logic                 stb,
    input logic [`MARKER_W-1:0] mrk,
    input logic                 gen2
  );
    logic [`PHY_W-1:0] result;
    result = word;
    for (int unsigned s = 0; s < `MARKER_W; s++) begin
      result[s*`PHY_SEG_W + `PHY_SEG_W - 1] = mrk[s];
    end
    // Unused strobe slot reads 0
    result[`STB_POS_GEN2] = gen2 ? stb : 1'b0;
    result[`STB_POS_GEN1] = gen2 ? 1'b0 : stb;
    return result;
  endfunction

  ////////////////////////////////////////////////////////////
  // Transmit

  // Payload muted until the link is aligned
  assign tx_payload = tx_online ? {{PAD_W{1'b0}}, tx_downstream_data} : '0;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      // Same strobe and markers on both channels
      tx_phy0 <= insert_ctrl(spread_payload(tx_payload[0 +: `PHY_PAYLOAD_W]),
                             tx_stb_userbit, tx_mrk_userbit, m_gen2_mode);
      tx_phy1 <= insert_ctrl(spread_payload(tx_payload[`PHY_PAYLOAD_W +: `PHY_PAYLOAD_W]),
                             tx_stb_userbit, tx_mrk_userbit, m_gen2_mode);
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive

  assign rx_payload = {gather_payload(rx_phy1), gather_payload(rx_phy0)};

  // Flit held at 0 while receive is offline
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_upstream_data <= '0;
    end else if (!rx_online) begin
      rx_upstream_data <= '0;
    end else begin
      rx_upstream_data <= rx_payload[`LPIF_FLIT_W-1:0];
    end
  end

endmodule

/* rtl/lpif_pkg.sv */
`include "lpif_settings.svh"

package lpif_pkg;

  ////////////////////////////////////////////////////////////
  // Link state carried in the flit state field

  typedef enum logic [`LPIF_STATE_W-1:0] {
    NOP       = 4'h0,
    ACTIVE    = 4'h1,
    DEAPPLSM  = 4'h4,
    LINKRESET = 4'h9,
    RETRAIN   = 4'hb
  } lpif_state_e;

  ////////////////////////////////////////////////////////////
  // Transmit alignment sequencer

  // Strobe training, then marker training, then user bits
  typedef enum logic [1:0] {
    SYNC_IDLE   = 2'd0,
    SYNC_STROBE = 2'd1,
    SYNC_MARKER = 2'd2,
    SYNC_ONLINE = 2'd3
  } sync_state_e;

endpackage

/* rtl/lpif_txrx_x8_q2_master_top.sv */
`timescale 1ns/1ps
`include "lpif_settings.svh"

module lpif_txrx_x8_q2_master_top
  import lpif_pkg::*;
(
  input  logic                      clk_wr,
  input  logic                      arst_n,
  // Link control
  input  logic                      tx_online,
  input  logic                      rx_online,
  // PHY channels
  output logic [`PHY_W-1:0]         tx_phy0,
  input  logic [`PHY_W-1:0]         rx_phy0,
  output logic [`PHY_W-1:0]         tx_phy1,
  input  logic [`PHY_W-1:0]         rx_phy1,
  // Downstream
  input  logic [`LPIF_STATE_W-1:0]  dstrm_state,
  input  logic [`LPIF_PROTID_W-1:0] dstrm_protid,
  input  logic [`LPIF_DATA_W-1:0]   dstrm_data,
  input  logic                      dstrm_dvalid,
  input  logic [`LPIF_CRC_W-1:0]    dstrm_crc,
  input  logic                      dstrm_crc_valid,
  input  logic                      dstrm_valid,
  // Upstream
  output lpif_state_e               ustrm_state,
  output logic [`LPIF_PROTID_W-1:0] ustrm_protid,
  output logic [`LPIF_DATA_W-1:0]   ustrm_data,
  output logic                      ustrm_dvalid,
  output logic [`LPIF_CRC_W-1:0]    ustrm_crc,
  output logic                      ustrm_crc_valid,
  output logic                      ustrm_valid,
  // Debug
  output logic [`LPIF_DBG_W-1:0]    tx_downstream_debug_status,
  output logic [`LPIF_DBG_W-1:0]    rx_upstream_debug_status,
  // Configuration
  input  logic                      m_gen2_mode,
  input  logic [`MARKER_W-1:0]      tx_mrk_userbit,
  input  logic                      tx_stb_userbit,
  // Word alignment time on the receive side
  input  logic [`DELAY_W-1:0]       delay_x_value,
  // Strobe and marker training lengths
  input  logic [`DELAY_W-1:0]       delay_y_value,
  input  logic [`DELAY_W-1:0]       delay_z_value
);

  ////////////////////////////////////////////////////////////
  // Internal wires

  logic [`LPIF_FLIT_W-1:0] txfifo_downstream_data;
  logic [`LPIF_FLIT_W-1:0] rx_upstream_data;
  logic [`MARKER_W-1:0]    tx_auto_mrk_userbit;
  logic                    tx_auto_stb_userbit;
  logic                    tx_online_delay;
  logic                    rx_online_delay;

  ////////////////////////////////////////////////////////////
  // Alignment sequencer

  ll_auto_sync ll_auto_sync_i (
    .clk_wr              (clk_wr),
    .arst_n              (arst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  ////////////////////////////////////////////////////////////
  // Flit packer

  // FIFO and credit path bypassed
  lpif_flit_pack lpif_flit_pack_i (
    .clk_wr                     (clk_wr),
    .arst_n                     (arst_n),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .rx_upstream_data           (rx_upstream_data),
    .txfifo_downstream_data     (txfifo_downstream_data),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

  ////////////////////////////////////////////////////////////
  // PHY mapper

  // Gated by the delayed online levels
  lpif_phy_concat lpif_phy_concat_i (
    .clk_wr             (clk_wr),
    .arst_n             (arst_n),
    .tx_downstream_data (txfifo_downstream_data),
    .rx_upstream_data   (rx_upstream_data),
    .tx_phy0            (tx_phy0),
    .rx_phy0            (rx_phy0),
    .tx_phy1            (tx_phy1),
    .rx_phy1            (rx_phy1),
    .m_gen2_mode        (m_gen2_mode),
    .tx_online          (tx_online_delay),
    .rx_online          (rx_online_delay),
    .tx_stb_userbit     (tx_auto_stb_userbit),
    .tx_mrk_userbit     (tx_auto_mrk_userbit)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the LPIF transmit/receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_lpif_txrx

rm -rf obj_dir "$LOG"

verilator --binary --timing --top-module tb_lpif_txrx -f project.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sim/tb_lpif_txrx.sv */
`timescale 1ns/1ps
`include "lpif_settings.svh"

module tb_lpif_txrx
  import lpif_pkg::*;
();

  typedef logic [`LPIF_FLIT_W-1:0] flit_t;
  typedef logic [`PHY_W-1:0]       phy_t;
  typedef logic [`LPIF_DATA_W-1:0] field_t;

  localparam int DELAY_X     = 4;
  localparam int DELAY_Y     = 5;
  localparam int DELAY_Z     = 3;
  localparam int WAIT_LIMIT  = 100;
  localparam int LOOP_FLITS  = 20;
  localparam int COUNT_FLITS = 40;

  logic                      clk_wr = 1'b0;
  logic                      arst_n;
  logic                      tx_online;
  logic                      rx_online;
  logic                      m_gen2_mode;
  logic [`MARKER_W-1:0]      tx_mrk_userbit;
  logic                      tx_stb_userbit;
  logic [`DELAY_W-1:0]       delay_x_value;
  logic [`DELAY_W-1:0]       delay_y_value;
  logic [`DELAY_W-1:0]       delay_z_value;
  phy_t                      tx_phy0;
  phy_t                      tx_phy1;
  phy_t                      rx_phy0;
  phy_t                      rx_phy1;
  phy_t                      rx_phy0_drv;
  phy_t                      rx_phy1_drv;
  logic                      loopback_en;
  logic [`LPIF_STATE_W-1:0]  dstrm_state;
  logic [`LPIF_PROTID_W-1:0] dstrm_protid;
  logic [`LPIF_DATA_W-1:0]   dstrm_data;
  logic                      dstrm_dvalid;
  logic [`LPIF_CRC_W-1:0]    dstrm_crc;
  logic                      dstrm_crc_valid;
  logic                      dstrm_valid;
  lpif_state_e               ustrm_state;
  logic [`LPIF_PROTID_W-1:0] ustrm_protid;
  logic [`LPIF_DATA_W-1:0]   ustrm_data;
  logic                      ustrm_dvalid;
  logic [`LPIF_CRC_W-1:0]    ustrm_crc;
  logic                      ustrm_crc_valid;
  logic                      ustrm_valid;
  logic [`LPIF_DBG_W-1:0]    tx_downstream_debug_status;
  logic [`LPIF_DBG_W-1:0]    rx_upstream_debug_status;

  int error_count = 0;
  int check_count = 0;
  int test_count  = 0;

  // 20 ns period
  always #10 clk_wr = ~clk_wr;

  // External loopback, or words from the testbench
  assign rx_phy0 = loopback_en ? tx_phy0 : rx_phy0_drv;
  assign rx_phy1 = loopback_en ? tx_phy1 : rx_phy1_drv;

  lpif_txrx_x8_q2_master_top i_lpif_txrx_x8_q2_master_top (
    .clk_wr                     (clk_wr),
    .arst_n                     (arst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .tx_phy0                    (tx_phy0),
    .rx_phy0                    (rx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy1                    (rx_phy1),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status),
    .m_gen2_mode                (m_gen2_mode),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .tx_stb_userbit             (tx_stb_userbit),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value)
  );

  ////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic compare_state(input string name, input lpif_state_e got,
                               input lpif_state_e exp);
    check_count++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_field(input string name, input field_t got, input field_t exp);
    check_count++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_word32(input string name, input logic [`LPIF_DBG_W-1:0] got,
                                input logic [`LPIF_DBG_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_phy(input string name, input phy_t got, input phy_t exp);
    check_count++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    error_count++;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Flit and PHY word model

  function automatic lpif_state_e random_state();
    case ($urandom % 5)
      0: return NOP;
      1: return ACTIVE;
      2: return DEAPPLSM;
      3: return RETRAIN;
      default: return LINKRESET;
    endcase
  endfunction

  // Random bits everywhere, a legal state on top
  function automatic flit_t random_flit();
    logic [543:0] bits;
    flit_t        flit;
    for (int i = 0; i < 17; i++) begin
      bits[i*32 +: 32] = $urandom;
    end
    flit          = bits[`LPIF_FLIT_W-1:0];
    flit[536:533] = random_state();
    return flit;
  endfunction

  // valid, crc_valid, crc, dvalid, data, protid, state from bit 0 up
  task automatic drive_fields(input flit_t flit);
    dstrm_valid     = flit[0];
    dstrm_crc_valid = flit[1];
    dstrm_crc       = flit[17:2];
    dstrm_dvalid    = flit[18];
    dstrm_data      = flit[530:19];
    dstrm_protid    = flit[532:531];
    dstrm_state     = flit[536:533];
  endtask

  task automatic check_upstream(input flit_t flit);
    compare_state("ustrm_state", ustrm_state, lpif_state_e'(flit[536:533]));
    compare_field("ustrm_protid", field_t'(ustrm_protid), field_t'(flit[532:531]));
    compare_field("ustrm_data", ustrm_data, field_t'(flit[530:19]));
    compare_bit("ustrm_dvalid", ustrm_dvalid, flit[18]);
    compare_field("ustrm_crc", field_t'(ustrm_crc), field_t'(flit[17:2]));
    compare_bit("ustrm_crc_valid", ustrm_crc_valid, flit[1]);
    compare_bit("ustrm_valid", ustrm_valid, flit[0]);
  endtask

  // Channel 0 takes flit bits 0..313, channel 1 the rest
  function automatic phy_t expected_phy(input flit_t flit, input int chan, input logic stb,
                                        input logic [`MARKER_W-1:0] mrk, input logic gen2);
    phy_t w;
    int   src;
    w   = '0;
    src = chan * `PHY_PAYLOAD_W;
    for (int pos = 0; pos < `PHY_W; pos++) begin
      if (pos == `STB_POS_GEN2) begin
        w[pos] = gen2 ? stb : 1'b0;
      end else if (pos == `STB_POS_GEN1) begin
        w[pos] = gen2 ? 1'b0 : stb;
      end else if ((pos % `PHY_SEG_W) == `PHY_SEG_W - 1) begin
        w[pos] = mrk[pos / `PHY_SEG_W];
      end else begin
        if (src < `LPIF_FLIT_W) begin
          w[pos] = flit[src];
        end
        src++;
      end
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // Transmit alignment sequence

  // Raises tx_online and walks both training phases
  task automatic run_alignment(input flit_t flit);
    phy_t strobe_word;
    phy_t marker_word;
    logic gen2;
    int   cycles;
    int   strobe_cycles;
    int   marker_cycles;
    int   guard;
    gen2          = m_gen2_mode;
    strobe_word   = expected_phy('0, 0, 1'b1, 4'hf, gen2);
    marker_word   = expected_phy('0, 0, 1'b0, 4'hf, gen2);
    cycles        = 0;
    strobe_cycles = 0;
    marker_cycles = 0;
    @(negedge clk_wr);
    tx_online = 1'b1;
    @(negedge clk_wr);
    cycles++;
    // One idle edge first
    guard = 0;
    while (tx_phy0 != strobe_word && guard < WAIT_LIMIT) begin
      @(negedge clk_wr);
      cycles++;
      guard++;
    end
    if (guard >= WAIT_LIMIT) begin
      report_failure("strobe training never started");
    end
    guard = 0;
    while (tx_phy0 == strobe_word && tx_phy1 == strobe_word && guard < WAIT_LIMIT) begin
      @(negedge clk_wr);
      cycles++;
      strobe_cycles++;
      guard++;
    end
    if (guard >= WAIT_LIMIT) begin
      report_failure("strobe training did not end");
    end
    guard = 0;
    while (tx_phy0 == marker_word && tx_phy1 == marker_word && guard < WAIT_LIMIT) begin
      @(negedge clk_wr);
      cycles++;
      marker_cycles++;
      guard++;
    end
    if (guard >= WAIT_LIMIT) begin
      report_failure("marker training did not end");
    end
    compare_word32("strobe training cycles", strobe_cycles, DELAY_Y);
    compare_word32("marker training cycles", marker_cycles, DELAY_Z);
    // Online at edge Y+Z+1, PHY register one edge later
    compare_word32("cycles to first payload", cycles, DELAY_Y + DELAY_Z + 2);
    compare_phy("tx_phy0", tx_phy0, expected_phy(flit, 0, 1'b0, 4'h0, gen2));
    compare_phy("tx_phy1", tx_phy1, expected_phy(flit, 1, 1'b0, 4'h0, gen2));
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests

  task automatic reset_test();
    int err0;
    err0 = error_count;
    compare_phy("tx_phy0", tx_phy0, '0);
    compare_phy("tx_phy1", tx_phy1, '0);
    check_upstream('0);
    compare_word32("tx_downstream_debug_status", tx_downstream_debug_status, 0);
    compare_word32("rx_upstream_debug_status", rx_upstream_debug_status, 0);
    finish_test("reset values", err0);
  endtask

  task automatic tx_align_test();
    flit_t flit;
    int    err0;
    err0    = error_count;
    flit    = random_flit();
    flit[0] = 1'b1;
    @(negedge clk_wr);
    m_gen2_mode    = 1'b1;
    tx_stb_userbit = 1'b0;
    tx_mrk_userbit = '0;
    drive_fields(flit);
    run_alignment(flit);
    finish_test("tx alignment", err0);
  endtask

  task automatic rx_gating_test();
    flit_t flit;
    int    k;
    int    err0;
    err0    = error_count;
    flit    = random_flit();
    flit[0] = 1'b1;
    @(negedge clk_wr);
    loopback_en = 1'b0;
    // Reserved bits set, the receiver drops them
    rx_phy0_drv = expected_phy(flit, 0, 1'b1, 4'hf, m_gen2_mode);
    rx_phy1_drv = expected_phy(flit, 1, 1'b1, 4'hf, m_gen2_mode);
    for (k = 0; k < 6; k++) begin
      @(negedge clk_wr);
      compare_bit("ustrm_valid", ustrm_valid, 1'b0);
    end
    rx_online = 1'b1;
    // Delay edge X+1, then one register stage
    for (k = 1; k <= DELAY_X + 3; k++) begin
      @(negedge clk_wr);
      compare_bit("ustrm_valid", ustrm_valid, k >= DELAY_X + 2);
    end
    check_upstream(flit);
    for (k = 0; k < 6; k++) begin
      flit        = random_flit();
      rx_phy0_drv = expected_phy(flit, 0, 1'b0, 4'h0, m_gen2_mode);
      rx_phy1_drv = expected_phy(flit, 1, 1'b0, 4'h0, m_gen2_mode);
      @(negedge clk_wr);
      check_upstream(flit);
    end
    finish_test("rx gating", err0);
  endtask

  task automatic loopback_test(input logic gen2, input string name);
    flit_t sent[$];
    flit_t flit;
    flit_t prev;
    int    i;
    int    err0;
    err0 = error_count;
    flit = '0;
    prev = '0;
    @(negedge clk_wr);
    loopback_en    = 1'b1;
    m_gen2_mode    = gen2;
    tx_stb_userbit = 1'b1;
    tx_mrk_userbit = 4'b1010;
    for (i = 0; i < LOOP_FLITS + 2; i++) begin
      if (i > 0) begin
        // Word launched from last cycle's fields
        compare_phy("tx_phy0", tx_phy0, expected_phy(prev, 0, 1'b1, 4'b1010, gen2));
        compare_phy("tx_phy1", tx_phy1, expected_phy(prev, 1, 1'b1, 4'b1010, gen2));
        compare_bit("tx_phy0 strobe", tx_phy0[gen2 ? `STB_POS_GEN2 : `STB_POS_GEN1], 1'b1);
        compare_bit("tx_phy0 spare strobe", tx_phy0[gen2 ? `STB_POS_GEN1 : `STB_POS_GEN2], 1'b0);
      end
      if (i > 1) begin
        check_upstream(sent.pop_front());
      end
      if (i < LOOP_FLITS) begin
        flit = random_flit();
        drive_fields(flit);
        sent.push_back(flit);
      end
      prev = flit;
      @(negedge clk_wr);
    end
    finish_test(name, err0);
  endtask

  task automatic counters_test();
    flit_t                  flit;
    logic [`LPIF_DBG_W-1:0] tx_start;
    logic [`LPIF_DBG_W-1:0] rx_start;
    int                     offered;
    int                     seen;
    int                     i;
    int                     err0;
    err0    = error_count;
    offered = 0;
    seen    = 0;
    @(negedge clk_wr);
    loopback_en = 1'b1;
    m_gen2_mode = 1'b1;
    // Drain the loopback pipe with idle flits
    drive_fields('0);
    for (i = 0; i < 3; i++) begin
      @(negedge clk_wr);
    end
    tx_start = tx_downstream_debug_status;
    rx_start = rx_upstream_debug_status;
    for (i = 0; i < COUNT_FLITS + 3; i++) begin
      if (ustrm_valid) begin
        seen++;
      end
      flit = (i < COUNT_FLITS) ? random_flit() : '0;
      if (flit[0]) begin
        offered++;
      end
      drive_fields(flit);
      @(negedge clk_wr);
    end
    compare_word32("tx_downstream_debug_status", tx_downstream_debug_status,
                   tx_start + offered);
    // Every offered valid flit comes back through the loopback
    compare_word32("rx_upstream_debug_status", rx_upstream_debug_status, rx_start + offered);
    compare_word32("received valid flits", seen, offered);
    finish_test("debug counters", err0);
  endtask

  task automatic offline_test();
    flit_t flit;
    int    k;
    int    err0;
    err0    = error_count;
    flit    = random_flit();
    flit[0] = 1'b1;
    @(negedge clk_wr);
    m_gen2_mode    = 1'b1;
    tx_stb_userbit = 1'b1;
    tx_mrk_userbit = 4'b0101;
    drive_fields(flit);
    @(negedge clk_wr);
    tx_online = 1'b0;
    // First edge still launches an online word
    @(negedge clk_wr);
    compare_phy("tx_phy0", tx_phy0, expected_phy(flit, 0, 1'b1, 4'b0101, 1'b1));
    for (k = 2; k <= 4; k++) begin
      @(negedge clk_wr);
      compare_phy("tx_phy0", tx_phy0, '0);
      compare_phy("tx_phy1", tx_phy1, '0);
    end
    tx_stb_userbit = 1'b0;
    tx_mrk_userbit = '0;
    run_alignment(flit);
    finish_test("going offline", err0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    void'($urandom(32'hf2b4));
    arst_n          = 1'b0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    m_gen2_mode     = 1'b1;
    tx_mrk_userbit  = '0;
    tx_stb_userbit  = 1'b0;
    delay_x_value   = 16'(DELAY_X);
    delay_y_value   = 16'(DELAY_Y);
    delay_z_value   = 16'(DELAY_Z);
    rx_phy0_drv     = '0;
    rx_phy1_drv     = '0;
    loopback_en     = 1'b0;
    drive_fields('0);
    repeat (10) @(negedge clk_wr);
    arst_n = 1'b1;
    reset_test();
    tx_align_test();
    rx_gating_test();
    loopback_test(1'b1, "loopback gen2");
    loopback_test(1'b0, "loopback gen1");
    counters_test();
    offline_test();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
